/* hdl/exu_pkg.sv */
package exu_pkg;

  // ----------------------------
  // Data widths
  // ----------------------------

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Reorder buffer tag width
  localparam int unsigned ROB_IDX_LEN = 4;

  // Unit control code width
  localparam int unsigned EU_CTL_LEN = 4;

  // Tag carried by every operation
  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // ----------------------------
  // Opcodes
  // ----------------------------

  // Divide unit operations
  typedef enum logic [EU_CTL_LEN-1:0] {
    DIV_DIV  = 4'h0,
    DIV_DIVU = 4'h1,
    DIV_REM  = 4'h2,
    DIV_REMU = 4'h3
  } div_op_t;

  // Multiply unit operations
  typedef enum logic [EU_CTL_LEN-1:0] {
    MUL_MUL    = 4'h0,
    MUL_MULH   = 4'h1,
    MUL_MULHU  = 4'h2,
    MUL_MULHSU = 4'h3
  } mul_op_t;

  // Exception causes, RISC-V numbering where it applies
  typedef enum logic [4:0] {
    E_NONE                = 5'h00,
    E_INSTR_ACCESS_FAULT  = 5'h01,
    E_ILLEGAL_INSTRUCTION = 5'h02,
    E_BREAKPOINT          = 5'h03
  } except_code_t;

endpackage

/* hdl/spill_cell_flush.sv */
`timescale 1ns/1ps

module spill_cell_flush #(
  parameter int unsigned DATA_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              valid_i,
  input  logic              ready_i,
  input  logic [DATA_W-1:0] data_i,
  output logic              valid_o,
  output logic              ready_o,
  output logic [DATA_W-1:0] data_o
);

  // Main and skid entries
  logic              main_valid_q;
  logic              skid_valid_q;
  logic [DATA_W-1:0] main_data_q;
  logic [DATA_W-1:0] skid_data_q;

  // Handshake events
  logic push;
  logic pop;
  logic main_load;

  // Ready from register state only
  assign ready_o = ~skid_valid_q;
  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;

  assign push      = valid_i & ready_o;
  assign pop       = main_valid_q & ready_i;
  // Main entry free this cycle
  assign main_load = pop | ~main_valid_q;

  // ----------------------------
  // Valid flags
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (flush_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      // Skid entry drains first to keep order
      main_valid_q <= skid_valid_q | push;
      skid_valid_q <= 1'b0;
    end else if (push) begin
      // Main entry stuck, park the word
      skid_valid_q <= 1'b1;
    end
  end

  // ----------------------------
  // Payload
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_data_q <= skid_valid_q ? skid_data_q : data_i;
    end
    if (!main_load && push) begin
      skid_data_q <= data_i;
    end
  end

endmodule

/* hdl/div_unit.sv */
`timescale 1ns/1ps

module div_unit import exu_pkg::*; #(
  parameter int unsigned PIPE_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  logic                  ready_i,
  input  logic [EU_CTL_LEN-1:0] ctl_i,
  input  rob_idx_t              rob_idx_i,
  input  logic [XLEN-1:0]       rs1_value_i,
  input  logic [XLEN-1:0]       rs2_value_i,
  output logic                  valid_o,
  output logic                  ready_o,
  output rob_idx_t              rob_idx_o,
  output logic [XLEN-1:0]       result_o,
  output logic                  except_raised_o
);

  // Spill cell word: result, tag, flag
  localparam int unsigned OUT_W = XLEN + ROB_IDX_LEN + 1;

  // Stage 0 outputs
  logic [XLEN-1:0] result;
  logic            except_raised;
  logic            div_by_zero;
  logic            sign_ovf;

  // Stage chain, index 0 is combinational
  logic            pipe_valid  [PIPE_DEPTH];
  logic [XLEN-1:0] pipe_result [PIPE_DEPTH];
  rob_idx_t        pipe_rob_idx[PIPE_DEPTH];
  logic            pipe_except [PIPE_DEPTH];

  // Stall control
  logic             advance;
  logic             out_ready;
  logic [OUT_W-1:0] out_data;

  // ----------------------------
  // Divide compute
  // ----------------------------
  assign div_by_zero = (rs2_value_i == '0);
  // Most negative over minus one
  assign sign_ovf    = (rs1_value_i == {1'b1, {(XLEN-1){1'b0}}}) & (&rs2_value_i);

  always_comb begin
    result        = '0;
    except_raised = 1'b0;
    case (ctl_i)
      DIV_DIV: begin
        if (div_by_zero) result = '1;
        else if (sign_ovf) result = rs1_value_i;
        else result = $signed(rs1_value_i) / $signed(rs2_value_i);
      end
      DIV_DIVU: begin
        if (div_by_zero) result = '1;
        else result = rs1_value_i / rs2_value_i;
      end
      DIV_REM: begin
        if (div_by_zero) result = rs1_value_i;
        else if (sign_ovf) result = '0;
        else result = $signed(rs1_value_i) % $signed(rs2_value_i);
      end
      DIV_REMU: begin
        if (div_by_zero) result = rs1_value_i;
        else result = rs1_value_i % rs2_value_i;
      end
      // Unknown code, zero result
      default: except_raised = 1'b1;
    endcase
  end

  // ----------------------------
  // Stall-able register chain
  // ----------------------------
  assign pipe_valid[0]   = valid_i;
  assign pipe_result[0]  = result;
  assign pipe_rob_idx[0] = rob_idx_i;
  assign pipe_except[0]  = except_raised;

  // Whole chain moves together
  assign advance = out_ready | ~pipe_valid[PIPE_DEPTH-1];
  assign ready_o = advance;

  for (genvar i = 1; i < PIPE_DEPTH; i++) begin : gen_stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) pipe_valid[i] <= 1'b0;
      else if (flush_i) pipe_valid[i] <= 1'b0;
      else if (advance) pipe_valid[i] <= pipe_valid[i-1];
    end
    always_ff @(posedge clk_i) begin
      if (advance) begin
        pipe_result[i]  <= pipe_result[i-1];
        pipe_rob_idx[i] <= pipe_rob_idx[i-1];
        pipe_except[i]  <= pipe_except[i-1];
      end
    end
  end

  // ----------------------------
  // Output spill cell
  // ----------------------------
  spill_cell_flush #(
    .DATA_W(OUT_W)
  ) u_out_reg (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i(pipe_valid[PIPE_DEPTH-1]),
    .ready_i(ready_i),
    .data_i ({pipe_result[PIPE_DEPTH-1], pipe_rob_idx[PIPE_DEPTH-1],
              pipe_except[PIPE_DEPTH-1]}),
    .valid_o(valid_o),
    .ready_o(out_ready),
    .data_o (out_data)
  );

  assign {result_o, rob_idx_o, except_raised_o} = out_data;

endmodule

/* hdl/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit import exu_pkg::*; #(
  parameter int unsigned PIPE_DEPTH = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  logic                  ready_i,
  input  logic [EU_CTL_LEN-1:0] ctl_i,
  input  rob_idx_t              rob_idx_i,
  input  logic [XLEN-1:0]       rs1_value_i,
  input  logic [XLEN-1:0]       rs2_value_i,
  output logic                  valid_o,
  output logic                  ready_o,
  output rob_idx_t              rob_idx_o,
  output logic [XLEN-1:0]       result_o,
  output logic                  except_raised_o
);

  localparam int unsigned OUT_W = XLEN + ROB_IDX_LEN + 1;

  // Full products for each signedness
  logic signed [2*XLEN-1:0] prod_ss;
  logic        [2*XLEN-1:0] prod_uu;
  logic signed [2*XLEN+1:0] prod_su;

  // Stage 0 outputs
  logic [XLEN-1:0] result;
  logic            except_raised;

  // Stage chain
  logic            pipe_valid  [PIPE_DEPTH];
  logic [XLEN-1:0] pipe_result [PIPE_DEPTH];
  rob_idx_t        pipe_rob_idx[PIPE_DEPTH];
  logic            pipe_except [PIPE_DEPTH];

  logic             advance;
  logic             out_ready;
  logic [OUT_W-1:0] out_data;

  // ----------------------------
  // Multiply compute
  // ----------------------------
  assign prod_ss = $signed(rs1_value_i) * $signed(rs2_value_i);
  assign prod_uu = rs1_value_i * rs2_value_i;
  // rs1 sign extended, rs2 zero extended
  assign prod_su = $signed({rs1_value_i[XLEN-1], rs1_value_i}) * $signed({1'b0, rs2_value_i});

  always_comb begin
    result        = '0;
    except_raised = 1'b0;
    case (ctl_i)
      MUL_MUL:    result = prod_uu[XLEN-1:0];
      MUL_MULH:   result = prod_ss[2*XLEN-1:XLEN];
      MUL_MULHU:  result = prod_uu[2*XLEN-1:XLEN];
      MUL_MULHSU: result = prod_su[2*XLEN-1:XLEN];
      default:    except_raised = 1'b1;
    endcase
  end

  // ----------------------------
  // Stall-able register chain
  // ----------------------------
  assign pipe_valid[0]   = valid_i;
  assign pipe_result[0]  = result;
  assign pipe_rob_idx[0] = rob_idx_i;
  assign pipe_except[0]  = except_raised;

  // Move when the output can take a word or the tail is a bubble
  assign advance = out_ready | ~pipe_valid[PIPE_DEPTH-1];
  assign ready_o = advance;

  for (genvar i = 1; i < PIPE_DEPTH; i++) begin : gen_stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) pipe_valid[i] <= 1'b0;
      else if (flush_i) pipe_valid[i] <= 1'b0;
      else if (advance) pipe_valid[i] <= pipe_valid[i-1];
    end
    always_ff @(posedge clk_i) begin
      if (advance) begin
        pipe_result[i]  <= pipe_result[i-1];
        pipe_rob_idx[i] <= pipe_rob_idx[i-1];
        pipe_except[i]  <= pipe_except[i-1];
      end
    end
  end

  // Output spill cell
  spill_cell_flush #(
    .DATA_W(OUT_W)
  ) u_out_reg (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i(pipe_valid[PIPE_DEPTH-1]),
    .ready_i(ready_i),
    .data_i ({pipe_result[PIPE_DEPTH-1], pipe_rob_idx[PIPE_DEPTH-1],
              pipe_except[PIPE_DEPTH-1]}),
    .valid_o(valid_o),
    .ready_o(out_ready),
    .data_o (out_data)
  );

  assign {result_o, rob_idx_o, except_raised_o} = out_data;

endmodule

/* hdl/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter import exu_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            div_valid_i,
  input  logic            mul_valid_i,
  input  logic [XLEN-1:0] div_result_i,
  input  logic [XLEN-1:0] mul_result_i,
  input  rob_idx_t        div_rob_idx_i,
  input  rob_idx_t        mul_rob_idx_i,
  input  logic            div_except_i,
  input  logic            mul_except_i,
  input  logic            cdb_ready_i,
  output logic            div_ready_o,
  output logic            mul_ready_o,
  output logic            cdb_valid_o,
  output logic [XLEN-1:0] cdb_result_o,
  output rob_idx_t        cdb_rob_idx_o,
  output logic            cdb_except_raised_o,
  output except_code_t    cdb_except_code_o
);

  // Last completed grant went to mul
  logic last_mul_q;
  // Stalled grant is pinned
  logic hold_q;
  logic hold_mul_q;

  logic rr_mul;
  logic hold_live;
  logic sel_mul;
  logic xfer;

  // ----------------------------
  // Grant selection
  // ----------------------------
  // Round robin, mul wins a tie only if div went last
  assign rr_mul    = mul_valid_i & (~div_valid_i | ~last_mul_q);
  // Held unit still has its word
  assign hold_live = hold_q & (hold_mul_q ? mul_valid_i : div_valid_i);
  assign sel_mul   = hold_live ? hold_mul_q : rr_mul;

  assign cdb_valid_o = sel_mul ? mul_valid_i : div_valid_i;
  assign xfer        = cdb_valid_o & cdb_ready_i;

  // Only the granted unit sees ready
  assign div_ready_o = ~sel_mul & cdb_ready_i;
  assign mul_ready_o = sel_mul & cdb_ready_i;

  // ----------------------------
  // Bus mux
  // ----------------------------
  assign cdb_result_o        = sel_mul ? mul_result_i : div_result_i;
  assign cdb_rob_idx_o       = sel_mul ? mul_rob_idx_i : div_rob_idx_i;
  assign cdb_except_raised_o = sel_mul ? mul_except_i : div_except_i;
  assign cdb_except_code_o   = cdb_except_raised_o ? E_ILLEGAL_INSTRUCTION : E_NONE;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_mul_q <= 1'b0;
      hold_q     <= 1'b0;
      hold_mul_q <= 1'b0;
    end else begin
      if (xfer) last_mul_q <= sel_mul;
      // Pin the grant while the bus waits
      hold_q     <= cdb_valid_o & ~cdb_ready_i;
      hold_mul_q <= sel_mul;
    end
  end

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
  parameter int unsigned DIV_PIPE_DEPTH = 4,
  parameter int unsigned MUL_PIPE_DEPTH = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,

  // Divide issue port
  input  logic                  div_valid_i,
  input  logic [EU_CTL_LEN-1:0] div_ctl_i,
  input  rob_idx_t              div_rob_idx_i,
  input  logic [XLEN-1:0]       div_rs1_i,
  input  logic [XLEN-1:0]       div_rs2_i,
  output logic                  div_ready_o,

  // Multiply issue port
  input  logic                  mul_valid_i,
  input  logic [EU_CTL_LEN-1:0] mul_ctl_i,
  input  rob_idx_t              mul_rob_idx_i,
  input  logic [XLEN-1:0]       mul_rs1_i,
  input  logic [XLEN-1:0]       mul_rs2_i,
  output logic                  mul_ready_o,

  // Common data bus
  input  logic                  cdb_ready_i,
  output logic                  cdb_valid_o,
  output logic [XLEN-1:0]       cdb_result_o,
  output rob_idx_t              cdb_rob_idx_o,
  output logic                  cdb_except_raised_o,
  output except_code_t          cdb_except_code_o
);

  // ----------------------------
  // Unit to arbiter wires
  // ----------------------------
  logic            div_out_valid;
  logic            div_out_ready;
  logic [XLEN-1:0] div_out_result;
  rob_idx_t        div_out_rob_idx;
  logic            div_out_except;

  logic            mul_out_valid;
  logic            mul_out_ready;
  logic [XLEN-1:0] mul_out_result;
  rob_idx_t        mul_out_rob_idx;
  logic            mul_out_except;

  // Divide unit
  div_unit #(
    .PIPE_DEPTH(DIV_PIPE_DEPTH)
  ) u_div (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .valid_i        (div_valid_i),
    .ready_i        (div_out_ready),
    .ctl_i          (div_ctl_i),
    .rob_idx_i      (div_rob_idx_i),
    .rs1_value_i    (div_rs1_i),
    .rs2_value_i    (div_rs2_i),
    .valid_o        (div_out_valid),
    .ready_o        (div_ready_o),
    .rob_idx_o      (div_out_rob_idx),
    .result_o       (div_out_result),
    .except_raised_o(div_out_except)
  );

  // Multiply unit
  mul_unit #(
    .PIPE_DEPTH(MUL_PIPE_DEPTH)
  ) u_mul (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .valid_i        (mul_valid_i),
    .ready_i        (mul_out_ready),
    .ctl_i          (mul_ctl_i),
    .rob_idx_i      (mul_rob_idx_i),
    .rs1_value_i    (mul_rs1_i),
    .rs2_value_i    (mul_rs2_i),
    .valid_o        (mul_out_valid),
    .ready_o        (mul_ready_o),
    .rob_idx_o      (mul_out_rob_idx),
    .result_o       (mul_out_result),
    .except_raised_o(mul_out_except)
  );

  // Shared result bus arbiter
  cdb_arbiter u_arb (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .div_valid_i        (div_out_valid),
    .mul_valid_i        (mul_out_valid),
    .div_result_i       (div_out_result),
    .mul_result_i       (mul_out_result),
    .div_rob_idx_i      (div_out_rob_idx),
    .mul_rob_idx_i      (mul_out_rob_idx),
    .div_except_i       (div_out_except),
    .mul_except_i       (mul_out_except),
    .cdb_ready_i        (cdb_ready_i),
    .div_ready_o        (div_out_ready),
    .mul_ready_o        (mul_out_ready),
    .cdb_valid_o        (cdb_valid_o),
    .cdb_result_o       (cdb_result_o),
    .cdb_rob_idx_o      (cdb_rob_idx_o),
    .cdb_except_raised_o(cdb_except_raised_o),
    .cdb_except_code_o  (cdb_except_code_o)
  );

endmodule

/* dv/exu_assertions.sv */
`timescale 1ns/1ps

module exu_assertions import exu_pkg::*; (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            cdb_ready_i,
  input logic            div_valid_i,
  input logic            mul_valid_i,
  input logic            cdb_valid_o,
  input logic [XLEN-1:0] cdb_result_o,
  input logic            div_ready_o,
  input logic            mul_ready_o
);

  // ----------------------------
  // CDB handshake
  // ----------------------------
  // Stalled word stays on the bus
  a_cdb_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cdb_valid_o && !cdb_ready_i |=> cdb_valid_o && $stable(cdb_result_o))
    else $error("CDB word changed while stalled");

  // Ready never goes to an empty unit while the other one waits
  a_div_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    div_ready_o && mul_valid_i |-> div_valid_i)
    else $error("div ready while div empty and mul waiting");
  a_mul_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mul_ready_o && div_valid_i |-> mul_valid_i)
    else $error("mul ready while mul empty and div waiting");

  // Bus idle in reset
  a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> !cdb_valid_o)
    else $error("CDB valid during reset");

endmodule

bind cdb_arbiter exu_assertions u_assert (.*);

/* dv/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

  localparam int TIMEOUT = 300;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  flush_i;
  logic                  div_valid_i;
  logic [EU_CTL_LEN-1:0] div_ctl_i;
  rob_idx_t              div_rob_idx_i;
  logic [XLEN-1:0]       div_rs1_i;
  logic [XLEN-1:0]       div_rs2_i;
  logic                  div_ready_o;
  logic                  mul_valid_i;
  logic [EU_CTL_LEN-1:0] mul_ctl_i;
  rob_idx_t              mul_rob_idx_i;
  logic [XLEN-1:0]       mul_rs1_i;
  logic [XLEN-1:0]       mul_rs2_i;
  logic                  mul_ready_o;
  logic                  cdb_ready_i;
  logic                  cdb_valid_o;
  logic [XLEN-1:0]       cdb_result_o;
  rob_idx_t              cdb_rob_idx_o;
  logic                  cdb_except_raised_o;
  except_code_t          cdb_except_code_o;

  // Expected and observed per ROB tag
  logic [XLEN-1:0] exp_result[16];
  except_code_t    exp_code[16];
  logic [XLEN-1:0] got_result[16];
  except_code_t    got_code[16];
  logic            got_raised[16];
  int              seen[16];
  rob_idx_t        got_order[$];

  int   value_errors;
  int   other_errors;
  logic alt_check;
  logic have_last;
  logic last_src_mul;

  exu_top u_dut (.*);

  // ----------------------------
  // Clock
  // ----------------------------
  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // ----------------------------
  // Reference model
  // ----------------------------
  function automatic logic [XLEN-1:0] ref_div(input logic [3:0] op,
                                              input logic [XLEN-1:0] a, b);
    longint sa;
    longint sb;
    longint q;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      DIV_DIV, DIV_REM: begin
        if (b == 0) return (op == DIV_DIV) ? 32'hFFFF_FFFF : a;
        // Overflow case keeps the dividend as quotient
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return (op == DIV_DIV) ? a : 32'h0;
        q = (op == DIV_DIV) ? sa / sb : sa % sb;
        return q[31:0];
      end
      DIV_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
      DIV_REMU: return (b == 0) ? a : a % b;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_mul(input logic [3:0] op,
                                              input logic [XLEN-1:0] a, b);
    longint          sa;
    longint          sb;
    longint          p;
    longint unsigned ua;
    longint unsigned ub;
    longint unsigned pu;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = a;
    ub = b;
    case (op)
      MUL_MUL: begin
        pu = ua * ub;
        return pu[31:0];
      end
      MUL_MULH: begin
        p = sa * sb;
        return p[63:32];
      end
      MUL_MULHU: begin
        pu = ua * ub;
        return pu[63:32];
      end
      MUL_MULHSU: begin
        // Unsigned operand fits in 33 bits and stays positive
        p = sa * longint'(ub);
        return p[63:32];
      end
      default: return 32'h0;
    endcase
  endfunction

  // ----------------------------
  // Compare tasks
  // ----------------------------
  task automatic check_result(input string name, input logic [XLEN-1:0] exp, act);
    if (exp !== act) begin
      value_errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rob_idx(input string name, input rob_idx_t exp, act);
    if (exp !== act) begin
      value_errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_except(input string name, input except_code_t exp, act);
    if (exp !== act) begin
      value_errors++;
      $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_flag(input string name, input logic exp, act);
    if (exp !== act) begin
      value_errors++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // CDB monitor sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i && cdb_valid_o && cdb_ready_i) begin
      seen[cdb_rob_idx_o]++;
      got_result[cdb_rob_idx_o] = cdb_result_o;
      got_code[cdb_rob_idx_o]   = cdb_except_code_o;
      got_raised[cdb_rob_idx_o] = cdb_except_raised_o;
      got_order.push_back(cdb_rob_idx_o);
      // Grant must swap while both units wait
      if (alt_check && have_last && u_dut.div_out_valid && u_dut.mul_out_valid &&
          u_dut.mul_out_ready == last_src_mul) begin
        other_errors++;
        $display("arbiter granted the same unit twice while both units waited");
      end
      have_last    = 1'b1;
      last_src_mul = u_dut.mul_out_ready;
    end
  end

  // ----------------------------
  // Issue tasks
  // ----------------------------
  task automatic issue_div(input logic [3:0] ctl, input rob_idx_t tag,
                           input logic [XLEN-1:0] a, b);
    int waited;
    waited         = 0;
    exp_result[tag] = ref_div(ctl, a, b);
    exp_code[tag]   = (ctl > 4'h3) ? E_ILLEGAL_INSTRUCTION : E_NONE;
    div_valid_i   = 1'b1;
    div_ctl_i     = ctl;
    div_rob_idx_i = tag;
    div_rs1_i     = a;
    div_rs2_i     = b;
    @(negedge clk_i);
    while (!div_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!div_ready_o) begin
      other_errors++;
      $display("div issue of tag %0d timed out waiting for ready", tag);
    end
    @(posedge clk_i);
    #1;
    div_valid_i = 1'b0;
  endtask

  task automatic issue_mul(input logic [3:0] ctl, input rob_idx_t tag,
                           input logic [XLEN-1:0] a, b);
    int waited;
    waited         = 0;
    exp_result[tag] = ref_mul(ctl, a, b);
    exp_code[tag]   = (ctl > 4'h3) ? E_ILLEGAL_INSTRUCTION : E_NONE;
    mul_valid_i   = 1'b1;
    mul_ctl_i     = ctl;
    mul_rob_idx_i = tag;
    mul_rs1_i     = a;
    mul_rs2_i     = b;
    @(negedge clk_i);
    while (!mul_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!mul_ready_o) begin
      other_errors++;
      $display("mul issue of tag %0d timed out waiting for ready", tag);
    end
    @(posedge clk_i);
    #1;
    mul_valid_i = 1'b0;
  endtask

  task automatic stream_div(input int lo, input int n);
    for (int i = 0; i < n; i++) begin
      issue_div(4'(i % 4), rob_idx_t'(lo + i), $urandom, $urandom % 1000);
    end
  endtask

  task automatic stream_mul(input int lo, input int n);
    for (int i = 0; i < n; i++) begin
      issue_mul(4'(i % 4), rob_idx_t'(lo + i), $urandom, $urandom);
    end
  endtask

  // ----------------------------
  // Tracking helpers
  // ----------------------------
  task automatic clear_tracking();
    for (int i = 0; i < 16; i++) seen[i] = 0;
    got_order.delete();
    have_last = 1'b0;
  endtask

  task automatic wait_tags(input string name, input int lo, input int hi);
    int  waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      waited++;
      done = 1'b1;
      for (int t = lo; t <= hi; t++) if (seen[t] == 0) done = 1'b0;
    end
    if (!done) begin
      other_errors++;
      $display("%s: timed out waiting for results on the CDB", name);
    end
  endtask

  task automatic verify_tags(input string name, input int lo, input int hi);
    for (int t = lo; t <= hi; t++) begin
      if (seen[t] != 1) begin
        other_errors++;
        $display("%s: tag %0d appeared %0d times on the CDB", name, t, seen[t]);
      end else begin
        check_result($sformatf("%s tag %0d", name, t), exp_result[t], got_result[t]);
        check_except($sformatf("%s tag %0d", name, t), exp_code[t], got_code[t]);
        check_flag($sformatf("%s tag %0d raised", name, t), exp_code[t] != E_NONE,
                   got_raised[t]);
      end
    end
  endtask

  // ----------------------------
  // Directed tests
  // ----------------------------
  task automatic test_div();
    clear_tracking();
    for (int i = 0; i < 8; i++) issue_div(4'(i % 4), rob_idx_t'(i), $urandom, $urandom);
    // Divide by zero and then most negative over minus one
    for (int i = 0; i < 4; i++) issue_div(4'(i), rob_idx_t'(8 + i), $urandom, 32'h0);
    for (int i = 0; i < 4; i++) issue_div(4'(i), rob_idx_t'(12 + i), 32'h8000_0000, '1);
    wait_tags("div_ops", 0, 15);
    verify_tags("div_ops", 0, 15);
    // Single in-order unit returns tags in issue order
    for (int i = 0; i < got_order.size(); i++) begin
      check_rob_idx("div_order", rob_idx_t'(i), got_order[i]);
    end
  endtask

  task automatic test_mul();
    clear_tracking();
    for (int i = 0; i < 8; i++) issue_mul(4'(i % 4), rob_idx_t'(i), $urandom, $urandom);
    for (int i = 0; i < 4; i++) issue_mul(4'(i), rob_idx_t'(8 + i), 32'h8000_0000, 32'h8000_0000);
    // Negative times negative
    for (int i = 0; i < 4; i++) issue_mul(4'(i), rob_idx_t'(12 + i), '1, 32'hFFFF_FFF0);
    wait_tags("mul_ops", 0, 15);
    verify_tags("mul_ops", 0, 15);
    for (int i = 0; i < got_order.size(); i++) begin
      check_rob_idx("mul_order", rob_idx_t'(i), got_order[i]);
    end
  endtask

  task automatic test_contention();
    clear_tracking();
    alt_check = 1'b1;
    fork
      stream_div(0, 8);
      stream_mul(8, 8);
    join
    wait_tags("contention", 0, 15);
    alt_check = 1'b0;
    verify_tags("contention", 0, 15);
  endtask

  task automatic test_backpressure();
    logic div_low;
    logic mul_low;
    div_low = 1'b0;
    mul_low = 1'b0;
    clear_tracking();
    cdb_ready_i = 1'b0;
    fork
      stream_div(0, 6);
      stream_mul(8, 6);
      begin
        repeat (40) begin
          @(negedge clk_i);
          if (!div_ready_o) div_low = 1'b1;
          if (!mul_ready_o) mul_low = 1'b1;
        end
        @(posedge clk_i);
        #1;
        cdb_ready_i = 1'b1;
      end
    join
    if (!div_low || !mul_low) begin
      other_errors++;
      $display("backpressure: issue ready never dropped on a unit");
    end
    wait_tags("backpressure", 0, 5);
    wait_tags("backpressure", 8, 13);
    verify_tags("backpressure", 0, 5);
    verify_tags("backpressure", 8, 13);
  endtask

  task automatic test_flush();
    clear_tracking();
    issue_div(DIV_DIV, 4'd0, 32'd100, 32'd7);
    fork
      issue_div(DIV_REM, 4'd1, 32'd100, 32'd7);
      issue_mul(MUL_MUL, 4'd2, 32'd3, 32'd5);
    join
    // Everything still inside the pipelines
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    repeat (20) @(negedge clk_i);
    for (int t = 0; t <= 2; t++) begin
      if (seen[t] != 0) begin
        other_errors++;
        $display("flush: flushed tag %0d reached the CDB", t);
      end
    end
    @(posedge clk_i);
    #1;
    fork
      issue_div(DIV_DIVU, 4'd8, 32'd1000, 32'd9);
      issue_mul(MUL_MULH, 4'd9, 32'hFFFF_0000, 32'd12345);
    join
    wait_tags("flush", 8, 9);
    verify_tags("flush", 8, 9);
  endtask

  task automatic test_illegal();
    clear_tracking();
    fork
      issue_div(4'hF, 4'd0, 32'd50, 32'd5);
      issue_mul(4'h9, 4'd1, 32'd6, 32'd7);
    join
    issue_div(4'h4, 4'd2, 32'd8, 32'd2);
    wait_tags("illegal", 0, 2);
    verify_tags("illegal", 0, 2);
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------
  initial begin
    void'($urandom(83));
    value_errors  = 0;
    other_errors  = 0;
    alt_check     = 1'b0;
    have_last     = 1'b0;
    last_src_mul  = 1'b0;
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    div_valid_i   = 1'b0;
    div_ctl_i     = '0;
    div_rob_idx_i = '0;
    div_rs1_i     = '0;
    div_rs2_i     = '0;
    mul_valid_i   = 1'b0;
    mul_ctl_i     = '0;
    mul_rob_idx_i = '0;
    mul_rs1_i     = '0;
    mul_rs2_i     = '0;
    cdb_ready_i   = 1'b1;
    clear_tracking();
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if (!div_ready_o || !mul_ready_o || cdb_valid_o) begin
      other_errors++;
      $display("after reset: issue ready low or CDB valid high");
    end
    @(posedge clk_i);
    #1;
    test_div();
    test_mul();
    test_contention();
    test_backpressure();
    test_flush();
    test_illegal();
    repeat (5) @(posedge clk_i);
    $display("errors: mismatch=%0d other=%0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/exu_pkg.sv
hdl/spill_cell_flush.sv
hdl/div_unit.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
hdl/exu_top.sv
dv/exu_assertions.sv
dv/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - hdl/exu_pkg.sv
  - hdl/spill_cell_flush.sv
  - hdl/div_unit.sv
  - hdl/mul_unit.sv
  - hdl/cdb_arbiter.sv
  - hdl/exu_top.sv
  - target: test
    files:
      - dv/exu_assertions.sv
      - dv/exu_tb.sv
